// ==== hdl/icache_macros.svh ====
// cache geometry; index and block offset must fit inside the page offset for VIPT lookup
`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

// geometry
`define ICACHE_SETS 64
`define ICACHE_WAYS 4
`define ICACHE_WORDS 4

// datapath widths
`define INSTR_W 32
`define VADDR_W 32

// address split, physical address is ptag followed by the page offset
`define PAGE_OFFSET_W 12
`define PTAG_W 20
`define INDEX_W 6
`define BLOCK_OFFSET_W 4

// replacement
`define WAY_W 2
`define LRU_W 3

`endif

// ==== hdl/icache_pkg.sv ====
// shared cache types; widths come from icache_macros.svh and a block packs word k at bits 32k up
`default_nettype none

`include "icache_macros.svh"

package icache_pkg;

  typedef logic [`PTAG_W-1:0] ptag_t;
  typedef logic [`INDEX_W-1:0] index_t;
  typedef logic [`WAY_W-1:0] way_t;
  typedef logic [`INSTR_W-1:0] instr_t;

  // word 0 sits in the low bits
  typedef logic [`ICACHE_WORDS-1:0][`INSTR_W-1:0] block_t;

  // single valid bit, no coherence state
  typedef struct packed {
    logic  valid;
    ptag_t tag;
  } tag_entry_t;

  // bit0 picks the half, bit1 and bit2 pick within it
  typedef logic [`LRU_W-1:0] lru_t;

  typedef enum logic {
    e_tag_clear_set,
    e_tag_write
  } tag_op_e;

endpackage

`default_nettype wire

// ==== hdl/icache_sram.sv ====
// one access per cycle, write wins over read; contents are not reset and accesses are ignored in reset
`timescale 1ns/1ps
`default_nettype none

`include "icache_macros.svh"

module icache_sram #(
  parameter type word_t = icache_pkg::block_t,
  parameter int depth = `ICACHE_SETS
) (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     en_i,
  input  logic                     we_i,
  input  logic [$clog2(depth)-1:0] addr_i,
  input  word_t                    wdata_i,
  output word_t                    rdata_o
);

  word_t mem [depth];

  // read data is latched and holds until the next read
  always_ff @(posedge clk_i) begin
    if (en_i && !reset_i) begin
      if (we_i) begin
        mem[addr_i] <= wdata_i;
      end else begin
        rdata_o <= mem[addr_i];
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/icache_fill_port.sv ====
// fetch owns the arrays whenever v_i is high; a fill data write always carries a whole block
`timescale 1ns/1ps
`default_nettype none

`include "icache_macros.svh"

module icache_fill_port (
  input  logic                     v_i,
  input  icache_pkg::index_t       vaddr_index_i,
  input  logic                     tag_wr_v_i,
  input  icache_pkg::tag_op_e      tag_wr_op_i,
  input  icache_pkg::index_t       tag_wr_index_i,
  input  icache_pkg::way_t         tag_wr_way_i,
  input  icache_pkg::ptag_t        tag_wr_tag_i,
  input  logic                     tag_wr_valid_i,
  output logic                     tag_wr_yumi_o,
  input  logic                     data_wr_v_i,
  input  icache_pkg::index_t       data_wr_index_i,
  input  icache_pkg::way_t         data_wr_way_i,
  input  icache_pkg::block_t       data_wr_block_i,
  output logic                     data_wr_yumi_o,
  output logic                     tag_en_o,
  output logic [`ICACHE_WAYS-1:0]  tag_we_o,
  output icache_pkg::index_t       tag_addr_o,
  output icache_pkg::tag_entry_t   tag_wdata_o,
  output logic                     data_en_o,
  output logic [`ICACHE_WAYS-1:0]  data_we_o,
  output icache_pkg::index_t       data_addr_o,
  output icache_pkg::block_t       data_wdata_o
);

  function automatic logic [`ICACHE_WAYS-1:0] way_onehot(input icache_pkg::way_t way);
    return {{(`ICACHE_WAYS-1){1'b0}}, 1'b1} << way;
  endfunction

  // lookup has priority over both fill ports
  assign tag_wr_yumi_o  = tag_wr_v_i & ~v_i;
  assign data_wr_yumi_o = data_wr_v_i & ~v_i;

  assign tag_en_o   = v_i | tag_wr_yumi_o;
  assign tag_addr_o = v_i ? vaddr_index_i : tag_wr_index_i;

  // set clear writes an invalid entry into every way
  always_comb begin
    tag_we_o    = '0;
    tag_wdata_o = '0;
    if (tag_wr_yumi_o) begin
      if (tag_wr_op_i == icache_pkg::e_tag_clear_set) begin
        tag_we_o = '1;
      end else begin
        tag_we_o          = way_onehot(tag_wr_way_i);
        tag_wdata_o.valid = tag_wr_valid_i;
        tag_wdata_o.tag   = tag_wr_tag_i;
      end
    end
  end

  assign data_en_o    = v_i | data_wr_yumi_o;
  assign data_addr_o  = v_i ? vaddr_index_i : data_wr_index_i;
  assign data_we_o    = data_wr_yumi_o ? way_onehot(data_wr_way_i) : '0;
  assign data_wdata_o = data_wr_block_i;

endmodule

`default_nettype wire

// ==== hdl/icache_lookup.sv ====
// two-stage TL/TV lookup; ptag must arrive in TL or the fetch is dropped, payload flops have no reset
`timescale 1ns/1ps
`default_nettype none

`include "icache_macros.svh"

module icache_lookup (
  input  logic                                      clk_i,
  input  logic                                      reset_i,
  input  logic                                      v_i,
  input  logic [`VADDR_W-1:0]                       vaddr_i,
  input  icache_pkg::ptag_t                         ptag_i,
  input  logic                                      ptag_v_i,
  input  icache_pkg::tag_entry_t [`ICACHE_WAYS-1:0] tag_rdata_i,
  input  icache_pkg::block_t [`ICACHE_WAYS-1:0]     data_rdata_i,
  output logic                                      tv_v_o,
  output logic                                      tv_hit_o,
  output icache_pkg::way_t                          tv_hit_way_o,
  output logic [`ICACHE_WAYS-1:0]                   tv_valid_ways_o,
  output icache_pkg::index_t                        tv_index_o,
  output logic [`PTAG_W+`PAGE_OFFSET_W-1:0]         tv_paddr_o,
  output icache_pkg::instr_t                        data_o
);

  localparam int word_sel_w = $clog2(`ICACHE_WORDS);
  localparam int blk_addr_w = `PTAG_W + `PAGE_OFFSET_W - `BLOCK_OFFSET_W;

  logic                      v_tl_r;
  logic [`PAGE_OFFSET_W-1:0] vaddr_tl_r;
  logic                      tv_we;
  logic [`ICACHE_WAYS-1:0]   hit_v_tl;
  logic [`ICACHE_WAYS-1:0]   valid_tl;

  logic                                  v_tv_r;
  logic [`ICACHE_WAYS-1:0]               hit_v_tv_r;
  logic [`ICACHE_WAYS-1:0]               valid_tv_r;
  logic [blk_addr_w-1:0]                 blk_addr_tv_r;
  logic [word_sel_w-1:0]                 word_tv_r;
  icache_pkg::block_t [`ICACHE_WAYS-1:0] data_tv_r;
  icache_pkg::way_t                      hit_way_tv;

  // TL stage, arrays are read in the same cycle as v_i
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      v_tl_r <= 1'b0;
    end else begin
      v_tl_r <= v_i;
    end
  end

  // only the page offset is needed past the array read
  always_ff @(posedge clk_i) begin
    if (v_i) begin
      vaddr_tl_r <= vaddr_i[`PAGE_OFFSET_W-1:0];
    end
  end

  for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_cmp
    assign valid_tl[w] = tag_rdata_i[w].valid;
    assign hit_v_tl[w] = tag_rdata_i[w].valid && (tag_rdata_i[w].tag == ptag_i);
  end

  assign tv_we = v_tl_r & ptag_v_i;

  // TV stage
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      v_tv_r <= 1'b0;
    end else begin
      v_tv_r <= tv_we;
    end
  end

  always_ff @(posedge clk_i) begin
    if (tv_we) begin
      hit_v_tv_r    <= hit_v_tl;
      valid_tv_r    <= valid_tl;
      blk_addr_tv_r <= {ptag_i, vaddr_tl_r[`PAGE_OFFSET_W-1:`BLOCK_OFFSET_W]};
      word_tv_r     <= vaddr_tl_r[`BLOCK_OFFSET_W-1:2];
      data_tv_r     <= data_rdata_i;
    end
  end

  // hit vector is one-hot, lowest way wins if not
  always_comb begin
    hit_way_tv = '0;
    for (int w = `ICACHE_WAYS-1; w >= 0; w--) begin
      if (hit_v_tv_r[w]) begin
        hit_way_tv = icache_pkg::way_t'(w);
      end
    end
  end

  assign tv_v_o          = v_tv_r;
  assign tv_hit_o        = |hit_v_tv_r;
  assign tv_hit_way_o    = hit_way_tv;
  assign tv_valid_ways_o = valid_tv_r;
  // low bits of the block address are paddr bits 9..4
  assign tv_index_o      = blk_addr_tv_r[`INDEX_W-1:0];
  assign tv_paddr_o      = {blk_addr_tv_r, {`BLOCK_OFFSET_W{1'b0}}};
  assign data_o          = data_tv_r[hit_way_tv][word_tv_r];

endmodule

`default_nettype wire

// ==== hdl/icache_replacement.sv ====
// tree-PLRU for four ways only; updated on TV hits, fills leave it alone
`timescale 1ns/1ps
`default_nettype none

`include "icache_macros.svh"

module icache_replacement (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    tv_v_i,
  input  logic                    tv_hit_i,
  input  icache_pkg::way_t        tv_hit_way_i,
  input  icache_pkg::index_t      tv_index_i,
  input  logic [`ICACHE_WAYS-1:0] tv_valid_ways_i,
  output icache_pkg::way_t        victim_way_o
);

  icache_pkg::lru_t lru_r [`ICACHE_SETS];
  icache_pkg::lru_t lru_cur;
  icache_pkg::lru_t lru_upd;
  icache_pkg::way_t tree_way;

  assign lru_cur = lru_r[tv_index_i];

  // walk the tree
  always_comb begin
    if (!lru_cur[0]) begin
      tree_way = {1'b0, lru_cur[1]};
    end else begin
      tree_way = {1'b1, lru_cur[2]};
    end
  end

  // lowest invalid way beats the tree
  always_comb begin
    victim_way_o = tree_way;
    for (int w = `ICACHE_WAYS-1; w >= 0; w--) begin
      if (!tv_valid_ways_i[w]) begin
        victim_way_o = icache_pkg::way_t'(w);
      end
    end
  end

  // point the tree away from the hit way
  always_comb begin
    lru_upd    = lru_cur;
    lru_upd[0] = ~tv_hit_way_i[1];
    if (tv_hit_way_i[1]) begin
      lru_upd[2] = ~tv_hit_way_i[0];
    end else begin
      lru_upd[1] = ~tv_hit_way_i[0];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int s = 0; s < `ICACHE_SETS; s++) begin
        lru_r[s] <= '0;
      end
    end else if (tv_v_i && tv_hit_i) begin
      lru_r[tv_index_i] <= lru_upd;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/icache_miss_ctrl.sv ====
// one outstanding miss; a TV miss while a fill is pending raises no request and must be refetched
`timescale 1ns/1ps
`default_nettype none

`include "icache_macros.svh"

module icache_miss_ctrl (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic                                tv_v_i,
  input  logic                                tv_hit_i,
  input  logic [`PTAG_W+`PAGE_OFFSET_W-1:0]   tv_paddr_i,
  input  icache_pkg::way_t                    victim_way_i,
  input  logic                                miss_req_ready_i,
  input  logic                                miss_done_i,
  output logic                                miss_req_v_o,
  output logic [`PTAG_W+`PAGE_OFFSET_W-1:0]   miss_req_addr_o,
  output logic                                miss_meta_v_o,
  output icache_pkg::way_t                    miss_meta_way_o,
  output logic                                data_v_o,
  output logic                                ready_o
);

  typedef enum logic {
    e_ready,
    e_miss
  } state_e;

  state_e state_r;
  state_e state_n;
  logic   miss_tv;

  assign miss_tv         = tv_v_i & ~tv_hit_i;
  assign miss_req_v_o    = miss_tv & miss_req_ready_i & (state_r == e_ready);
  assign miss_req_addr_o = tv_paddr_i;
  assign data_v_o        = tv_v_i & tv_hit_i;

  // tracker
  always_comb begin
    case (state_r)
      e_ready: state_n = miss_req_v_o ? e_miss : e_ready;
      e_miss:  state_n = miss_done_i ? e_ready : e_miss;
      default: state_n = e_ready;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r       <= e_ready;
      miss_meta_v_o <= 1'b0;
    end else begin
      state_r       <= state_n;
      miss_meta_v_o <= miss_req_v_o;
    end
  end

  // metadata trails the request by one cycle
  always_ff @(posedge clk_i) begin
    if (miss_req_v_o) begin
      miss_meta_way_o <= victim_way_i;
    end
  end

  assign ready_o = (state_r == e_ready) & miss_req_ready_i & ~miss_req_v_o;

endmodule

`default_nettype wire

// ==== hdl/icache_top.sv ====
// 4-way VIPT instruction cache; fetch only while ready_o, ptag one cycle later, fills wait on yumi
`timescale 1ns/1ps
`default_nettype none

`include "icache_macros.svh"

module icache_top (
  input  logic                              clk_i,
  input  logic                              reset_i,
  input  logic                              v_i,
  input  logic [`VADDR_W-1:0]               vaddr_i,
  output logic                              ready_o,
  input  icache_pkg::ptag_t                 ptag_i,
  input  logic                              ptag_v_i,
  output icache_pkg::instr_t                data_o,
  output logic                              data_v_o,
  output logic                              miss_req_v_o,
  output logic [`PTAG_W+`PAGE_OFFSET_W-1:0] miss_req_addr_o,
  input  logic                              miss_req_ready_i,
  output logic                              miss_meta_v_o,
  output icache_pkg::way_t                  miss_meta_way_o,
  input  logic                              miss_done_i,
  input  logic                              tag_wr_v_i,
  input  icache_pkg::tag_op_e               tag_wr_op_i,
  input  icache_pkg::index_t                tag_wr_index_i,
  input  icache_pkg::way_t                  tag_wr_way_i,
  input  icache_pkg::ptag_t                 tag_wr_tag_i,
  input  logic                              tag_wr_valid_i,
  output logic                              tag_wr_yumi_o,
  input  logic                              data_wr_v_i,
  input  icache_pkg::index_t                data_wr_index_i,
  input  icache_pkg::way_t                  data_wr_way_i,
  input  icache_pkg::block_t                data_wr_block_i,
  output logic                              data_wr_yumi_o
);

  logic                                  tag_en;
  logic [`ICACHE_WAYS-1:0]               tag_we;
  icache_pkg::index_t                    tag_addr;
  icache_pkg::tag_entry_t                tag_wdata;
  icache_pkg::tag_entry_t [`ICACHE_WAYS-1:0] tag_rdata;
  logic                                  data_en;
  logic [`ICACHE_WAYS-1:0]               data_we;
  icache_pkg::index_t                    data_addr;
  icache_pkg::block_t                    data_wdata;
  icache_pkg::block_t [`ICACHE_WAYS-1:0] data_rdata;

  logic                              tv_v;
  logic                              tv_hit;
  icache_pkg::way_t                  tv_hit_way;
  logic [`ICACHE_WAYS-1:0]           tv_valid_ways;
  icache_pkg::index_t                tv_index;
  logic [`PTAG_W+`PAGE_OFFSET_W-1:0] tv_paddr;
  icache_pkg::way_t                  victim_way;

  icache_fill_port fill_port_inst (
    .v_i(v_i),
    .vaddr_index_i(vaddr_i[`BLOCK_OFFSET_W +: `INDEX_W]),
    .tag_wr_v_i(tag_wr_v_i),
    .tag_wr_op_i(tag_wr_op_i),
    .tag_wr_index_i(tag_wr_index_i),
    .tag_wr_way_i(tag_wr_way_i),
    .tag_wr_tag_i(tag_wr_tag_i),
    .tag_wr_valid_i(tag_wr_valid_i),
    .tag_wr_yumi_o(tag_wr_yumi_o),
    .data_wr_v_i(data_wr_v_i),
    .data_wr_index_i(data_wr_index_i),
    .data_wr_way_i(data_wr_way_i),
    .data_wr_block_i(data_wr_block_i),
    .data_wr_yumi_o(data_wr_yumi_o),
    .tag_en_o(tag_en),
    .tag_we_o(tag_we),
    .tag_addr_o(tag_addr),
    .tag_wdata_o(tag_wdata),
    .data_en_o(data_en),
    .data_we_o(data_we),
    .data_addr_o(data_addr),
    .data_wdata_o(data_wdata)
  );

  // one tag array and one data array per way
  for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
    icache_sram #(
      .word_t(icache_pkg::tag_entry_t),
      .depth(`ICACHE_SETS)
    ) tag_sram_inst (
      .clk_i(clk_i),
      .reset_i(reset_i),
      .en_i(tag_en),
      .we_i(tag_we[w]),
      .addr_i(tag_addr),
      .wdata_i(tag_wdata),
      .rdata_o(tag_rdata[w])
    );

    icache_sram #(
      .word_t(icache_pkg::block_t),
      .depth(`ICACHE_SETS)
    ) data_sram_inst (
      .clk_i(clk_i),
      .reset_i(reset_i),
      .en_i(data_en),
      .we_i(data_we[w]),
      .addr_i(data_addr),
      .wdata_i(data_wdata),
      .rdata_o(data_rdata[w])
    );
  end

  icache_lookup lookup_inst (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .v_i(v_i),
    .vaddr_i(vaddr_i),
    .ptag_i(ptag_i),
    .ptag_v_i(ptag_v_i),
    .tag_rdata_i(tag_rdata),
    .data_rdata_i(data_rdata),
    .tv_v_o(tv_v),
    .tv_hit_o(tv_hit),
    .tv_hit_way_o(tv_hit_way),
    .tv_valid_ways_o(tv_valid_ways),
    .tv_index_o(tv_index),
    .tv_paddr_o(tv_paddr),
    .data_o(data_o)
  );

  icache_replacement replacement_inst (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .tv_v_i(tv_v),
    .tv_hit_i(tv_hit),
    .tv_hit_way_i(tv_hit_way),
    .tv_index_i(tv_index),
    .tv_valid_ways_i(tv_valid_ways),
    .victim_way_o(victim_way)
  );

  icache_miss_ctrl miss_ctrl_inst (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .tv_v_i(tv_v),
    .tv_hit_i(tv_hit),
    .tv_paddr_i(tv_paddr),
    .victim_way_i(victim_way),
    .miss_req_ready_i(miss_req_ready_i),
    .miss_done_i(miss_done_i),
    .miss_req_v_o(miss_req_v_o),
    .miss_req_addr_o(miss_req_addr_o),
    .miss_meta_v_o(miss_meta_v_o),
    .miss_meta_way_o(miss_meta_way_o),
    .data_v_o(data_v_o),
    .ready_o(ready_o)
  );

endmodule

`default_nettype wire

// ==== verif/icache_assert.sv ====
// port-level protocol checks only; internal pipeline state of the cache is not observed
`timescale 1ns/1ps
`default_nettype none

module icache_assert (
  input logic clk_i,
  input logic reset_i,
  input logic v_i,
  input logic ready_o,
  input logic data_v_o,
  input logic miss_req_v_o,
  input logic miss_meta_v_o
);

  int fail_count = 0;

  fetch_needs_ready: assert property (@(posedge clk_i) disable iff (reset_i) v_i |-> ready_o)
    else begin
      $error("fetch valid while the cache is not ready");
      fail_count = fail_count + 1;
    end

  // metadata trails every request by exactly one cycle
  meta_after_req: assert property (@(posedge clk_i) disable iff (reset_i)
      miss_req_v_o |=> miss_meta_v_o)
    else begin
      $error("miss metadata did not follow the miss request");
      fail_count = fail_count + 1;
    end

  hit_or_miss: assert property (@(posedge clk_i) disable iff (reset_i)
      !(data_v_o && miss_req_v_o))
    else begin
      $error("hit data and miss request raised in the same cycle");
      fail_count = fail_count + 1;
    end

  // first reset edge clears the flops, so only later reset cycles are checked
  quiet_in_reset: assert property (@(posedge clk_i) (reset_i && $past(reset_i))
      |-> !(data_v_o || miss_req_v_o || miss_meta_v_o))
    else begin
      $error("cache outputs active during reset");
      fail_count = fail_count + 1;
    end

endmodule

bind icache_top icache_assert assert_inst (
  .clk_i(clk_i),
  .reset_i(reset_i),
  .v_i(v_i),
  .ready_o(ready_o),
  .data_v_o(data_v_o),
  .miss_req_v_o(miss_req_v_o),
  .miss_meta_v_o(miss_meta_v_o)
);

`default_nettype wire

// ==== verif/icache_tb.sv ====
// run from the project root so verif/icache_golden.txt is found; miss_req_ready_i stays high
`timescale 1ns/1ps
`default_nettype none

`include "icache_macros.svh"

module icache_tb;

  localparam string golden_path = "verif/icache_golden.txt";
  localparam int cycles_per_rec = 12;

  logic                              clk_i;
  logic                              reset_i;
  logic                              v_i;
  logic [`VADDR_W-1:0]               vaddr_i;
  logic                              ready_o;
  icache_pkg::ptag_t                 ptag_i;
  logic                              ptag_v_i;
  icache_pkg::instr_t                data_o;
  logic                              data_v_o;
  logic                              miss_req_v_o;
  logic [`PTAG_W+`PAGE_OFFSET_W-1:0] miss_req_addr_o;
  logic                              miss_req_ready_i;
  logic                              miss_meta_v_o;
  icache_pkg::way_t                  miss_meta_way_o;
  logic                              miss_done_i;
  logic                              tag_wr_v_i;
  icache_pkg::tag_op_e               tag_wr_op_i;
  icache_pkg::index_t                tag_wr_index_i;
  icache_pkg::way_t                  tag_wr_way_i;
  icache_pkg::ptag_t                 tag_wr_tag_i;
  logic                              tag_wr_valid_i;
  logic                              tag_wr_yumi_o;
  logic                              data_wr_v_i;
  icache_pkg::index_t                data_wr_index_i;
  icache_pkg::way_t                  data_wr_way_i;
  icache_pkg::block_t                data_wr_block_i;
  logic                              data_wr_yumi_o;

  // one entry per golden record, field meaning depends on the kind
  logic [7:0]   rec_kind [$];
  logic [31:0]  rec_a [$];
  logic [31:0]  rec_b [$];
  logic [31:0]  rec_c [$];
  logic [127:0] rec_d [$];
  logic [31:0]  rec_e [$];

  int seed;
  int checks;
  int errors;
  int cycles;
  int limit;

  icache_top icache_top_inst (.*);

  always #10 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("timeout: the run did not finish within %0d cycles", limit);
      $display("Errors found");
      $finish;
    end
  end

  task automatic check_val(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    checks = checks + 1;
    if (actual !== expected) begin
      errors = errors + 1;
      $display("[ERROR] %s: expected 0x%h, got 0x%h at %0t", name, expected, actual, $time);
    end
  endtask

  task automatic load_records(output bit ok);
    int fd;
    int n;
    string line;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [127:0] d;
    logic [31:0] e;
    ok = 1'b0;
    fd = $fopen(golden_path, "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (n > 1 && line.getc(0) != "#") begin
          a = '0;
          b = '0;
          c = '0;
          d = '0;
          e = '0;
          n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h", a, b, c, d, e);
          rec_kind.push_back(line.getc(0));
          rec_a.push_back(a);
          rec_b.push_back(b);
          rec_c.push_back(c);
          rec_d.push_back(d);
          rec_e.push_back(e);
        end
      end
      $fclose(fd);
      ok = (rec_kind.size() > 0);
    end
  endtask

  task automatic idle_gap();
    int gap;
    int k;
    gap = $random(seed) & 3;
    for (k = 0; k < gap; k++) begin
      @(posedge clk_i);
    end
  endtask

  task automatic wait_ready();
    @(negedge clk_i);
    while (!ready_o) begin
      @(negedge clk_i);
    end
  endtask

  // TV outputs of fetch record r, sampled mid-cycle
  task automatic check_tv(input int r);
    if (rec_c[r][0]) begin
      check_val("data_v_o", 32'd1, 32'(data_v_o));
      check_val("miss_req_v_o", 32'd0, 32'(miss_req_v_o));
      check_val("data_o", rec_d[r][31:0], data_o);
    end else begin
      check_val("data_v_o", 32'd0, 32'(data_v_o));
      check_val("miss_req_v_o", 32'd1, 32'(miss_req_v_o));
      check_val("miss_req_addr_o", rec_d[r][31:0], miss_req_addr_o);
      check_val("ready_o", 32'd0, 32'(ready_o));
    end
  endtask

  // ptag trails each vaddr by one cycle, results two cycles after v_i
  task automatic issue_fetches(input int first, input int n, output bit missed);
    int k;
    int last;
    last = first + n - 1;
    wait_ready();
    for (k = 0; k < n + 2; k++) begin
      @(posedge clk_i);
      v_i <= (k < n);
      if (k < n) begin
        vaddr_i <= rec_a[first + k];
      end
      ptag_v_i <= (k >= 1 && k <= n);
      if (k >= 1 && k <= n) begin
        ptag_i <= rec_b[first + k - 1][`PTAG_W-1:0];
      end
      if (k >= 2) begin
        @(negedge clk_i);
        check_tv(first + k - 2);
      end
    end
    missed = !rec_c[last][0];
    if (missed) begin
      @(negedge clk_i);
      check_val("miss_meta_v_o", 32'd1, 32'(miss_meta_v_o));
      check_val("miss_meta_way_o", rec_e[last], 32'(miss_meta_way_o));
      check_val("ready_o", 32'd0, 32'(ready_o));
    end
  endtask

  task automatic write_arrays(input icache_pkg::index_t index, input icache_pkg::way_t way,
                              input icache_pkg::ptag_t tag, input logic [127:0] block,
                              input bit clear, input bit in_miss);
    bit tag_done;
    bit data_done;
    bit first;
    tag_done = 1'b0;
    data_done = clear;
    first = 1'b1;
    @(posedge clk_i);
    tag_wr_v_i <= 1'b1;
    tag_wr_op_i <= clear ? icache_pkg::e_tag_clear_set : icache_pkg::e_tag_write;
    tag_wr_index_i <= index;
    tag_wr_way_i <= way;
    tag_wr_tag_i <= tag;
    tag_wr_valid_i <= 1'b1;
    data_wr_v_i <= !clear;
    data_wr_index_i <= index;
    data_wr_way_i <= way;
    data_wr_block_i <= block;
    while (!(tag_done && data_done)) begin
      @(negedge clk_i);
      if (in_miss) begin
        check_val("ready_o", 32'd0, 32'(ready_o));
      end
      // no fetch in flight, so every port with a request is taken at once
      if (first) begin
        check_val("tag_wr_yumi_o", 32'd1, 32'(tag_wr_yumi_o));
        check_val("data_wr_yumi_o", 32'(!clear), 32'(data_wr_yumi_o));
        first = 1'b0;
      end
      if (tag_wr_yumi_o) begin
        tag_done = 1'b1;
      end
      if (data_wr_yumi_o) begin
        data_done = 1'b1;
      end
      @(posedge clk_i);
      if (tag_done) begin
        tag_wr_v_i <= 1'b0;
      end
      if (data_done) begin
        data_wr_v_i <= 1'b0;
      end
    end
  endtask

  // tracker stays in miss through the done cycle
  task automatic finish_miss();
    @(posedge clk_i);
    miss_done_i <= 1'b1;
    @(negedge clk_i);
    check_val("ready_o", 32'd0, 32'(ready_o));
    @(posedge clk_i);
    miss_done_i <= 1'b0;
    @(negedge clk_i);
    check_val("ready_o", 32'd1, 32'(ready_o));
  endtask

  task automatic run_records();
    int i;
    bit miss_pending;
    i = 0;
    miss_pending = 1'b0;
    while (i < rec_kind.size()) begin
      idle_gap();
      if (rec_kind[i] == "F") begin
        write_arrays(rec_a[i][`INDEX_W-1:0], rec_b[i][`WAY_W-1:0], rec_c[i][`PTAG_W-1:0],
                     rec_d[i], 1'b0, miss_pending);
        if (miss_pending) begin
          finish_miss();
        end
        miss_pending = 1'b0;
        i = i + 1;
      end else if (rec_kind[i] == "C") begin
        write_arrays(rec_a[i][`INDEX_W-1:0], '0, '0, '0, 1'b1, 1'b0);
        i = i + 1;
      end else if (rec_kind[i] == "B") begin
        issue_fetches(i + 1, int'(rec_a[i]), miss_pending);
        i = i + 1 + int'(rec_a[i]);
      end else if (rec_kind[i] == "R") begin
        issue_fetches(i, 1, miss_pending);
        i = i + 1;
      end else begin
        $display("unknown record type in the golden file at record %0d", i);
        errors = errors + 1;
        i = i + 1;
      end
    end
  endtask

  task automatic report_end();
    int assert_fails;
    assert_fails = icache_top_inst.assert_inst.fail_count;
    $display("%0d checks, %0d mismatches, %0d assertion failures", checks, errors,
             assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  endtask

  initial begin
    bit loaded;
    seed = 32'hbe7a_2261;
    checks = 0;
    errors = 0;
    cycles = 0;
    limit = 0;
    clk_i = 1'b0;
    reset_i <= 1'b1;
    v_i <= 1'b0;
    vaddr_i <= '0;
    ptag_i <= '0;
    ptag_v_i <= 1'b0;
    miss_req_ready_i <= 1'b1;
    miss_done_i <= 1'b0;
    tag_wr_v_i <= 1'b0;
    tag_wr_op_i <= icache_pkg::e_tag_write;
    tag_wr_index_i <= '0;
    tag_wr_way_i <= '0;
    tag_wr_tag_i <= '0;
    tag_wr_valid_i <= 1'b0;
    data_wr_v_i <= 1'b0;
    data_wr_index_i <= '0;
    data_wr_way_i <= '0;
    data_wr_block_i <= '0;
    load_records(loaded);
    if (!loaded) begin
      $display("could not read any record from %s", golden_path);
      $display("Errors found");
      $finish;
    end else begin
      limit = rec_kind.size() * cycles_per_rec + 50;
      repeat (10) @(posedge clk_i);
      reset_i <= 1'b0;
      run_records();
      report_end();
    end
  end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+hdl
hdl/icache_pkg.sv
hdl/icache_sram.sv
hdl/icache_fill_port.sv
hdl/icache_lookup.sv
hdl/icache_replacement.sv
hdl/icache_miss_ctrl.sv
hdl/icache_top.sv
verif/icache_assert.sv
verif/icache_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the icache testbench with Verilator, runs it and looks for the pass message
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert -j 0 -f tb.f --top-module icache_tb; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vicache_tb +verilator+error+limit+100 2>&1)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "No errors" <<< "$output"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1

// ==== verif/icache_golden.txt ====
# F index way ptag block(word3..word0) | C index | B count of back-to-back fetches that follow
# R vaddr ptag hit instr_or_miss_addr victim_way; all fields hex, a miss is refilled by the next F
C 05
C 2a
R 80001050 12345 0 12345050 0
F 05 0 12345 a3a33333a2a22222a1a11111a0a00000
B 4
R 80001050 12345 1 a0a00000 0
R 80001054 12345 1 a1a11111 0
R 80001058 12345 1 a2a22222 0
R 8000105c 12345 1 a3a33333 0
R 7ffff2a0 00100 0 001002a0 0
F 2a 0 00100 00100003001000020010000100100000
F 2a 1 00200 00200003002000020020000100200000
F 2a 2 00300 00300003003000020030000100300000
F 2a 3 00400 00400003004000020040000100400000
R 7ffff2a4 00300 1 00300001 0
R 7ffff2ac 00100 1 00100003 0
R 7ffff2a0 00400 1 00400000 0
R 7ffff2a8 00500 0 005002a0 1
F 2a 1 00500 00500003005000020050000100500000
R 7ffff2a8 00500 1 00500002 0
R 7ffff2a0 00200 0 002002a0 2
F 2a 2 00200 00200003002000020020000100200000
R 7ffff2a4 00200 1 00200001 0
B 2
R 7ffff2a0 00400 1 00400000 0
R 7ffff2ac 00500 1 00500003 0
R 80001050 54321 0 54321050 1
F 05 1 54321 54321003543210025432100154321000
C 05
R 80001054 12345 0 12345050 0
F 05 0 12345 b3b33333b2b22222b1b11111b0b00000
R 8000105c 12345 1 b3b33333 0
